// ==== verilog/dsp_settings.svh ====
/* Sample divider, phase width, sine table address width and FIR tap count */

`ifndef DSP_SETTINGS_SVH
`define DSP_SETTINGS_SVH

// System clocks per sample strobe
`define SAMPLE_DIV 50

// Phase accumulator and increment width
`define PHASE_W 16

// Sine table address width, taken from the top phase bits
`define LUT_AW 10

// FIR length, odd so the centre tap has no mirror
`define NUM_TAPS 17

`endif

// ==== verilog/dsp_pkg.sv ====
/* Sample, mix, accumulator, phase and coefficient types,
   low-pass coefficient table and sine table function */

`default_nettype none

`include "dsp_settings.svh"

package dsp_pkg;

    ////////////////////////////////////////////////////////////
    // Data types
    ////////////////////////////////////////////////////////////

    // One tone or external sample
    typedef logic signed [15:0] sample_t;
    // Sum of two samples, one guard bit
    typedef logic signed [16:0] mix_t;
    // Filter result, pre-added tap times coefficient
    typedef logic signed [33:0] acc_t;
    // Phase word, wraps freely
    typedef logic [`PHASE_W-1:0] phase_t;
    // Q15 coefficient
    typedef logic signed [15:0] coef_t;

    ////////////////////////////////////////////////////////////
    // Low-pass coefficients
    ////////////////////////////////////////////////////////////

    // Passband near 0.02 Fs, stopband near 0.17 Fs
    // Symmetric around tap 8, DC gain about 0.94
    localparam coef_t LP_COEFS [`NUM_TAPS] = '{
        16'sd12,   16'sd71,   16'sd246,  16'sd640,
        16'sd1345, 16'sd2363, 16'sd3556, 16'sd4655,
        16'sd5133,
        16'sd4655, 16'sd3556, 16'sd2363, 16'sd1345,
        16'sd640,  16'sd246,  16'sd71,   16'sd12
    };

    ////////////////////////////////////////////////////////////
    // Sine table
    ////////////////////////////////////////////////////////////

    localparam real PI = 3.14159265358979323846;

    // Full-scale sine for one table index, evaluated at elaboration
    function automatic sample_t sine_at(input int unsigned idx);
        real ang;
        real val;
        ang = 2.0 * PI * real'(idx) / real'(1 << `LUT_AW);
        val = 32767.0 * $sin(ang);
        // Cast from real rounds to nearest
        return sample_t'(int'(val));
    endfunction

endpackage

`default_nettype wire

// ==== verilog/sample_clock_enable.sv ====
/* Terminal-count divider making the one-cycle sample strobe */

`timescale 1ns/1ns
`default_nettype none

`include "dsp_settings.svh"

module sample_clock_enable
(
    input  wire  clk,
    input  wire  rst_n,
    output logic sample_en
);

    // Counter wide enough for SAMPLE_DIV-1
    localparam int CNT_W = (`SAMPLE_DIV > 1) ? $clog2(`SAMPLE_DIV) : 1;
    localparam logic [CNT_W-1:0] TERM = CNT_W'(`SAMPLE_DIV - 1);

    logic [CNT_W-1:0] count;

    // Wrap at terminal count, strobe registered on the wrap
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            count     <= '0;
            sample_en <= 1'b0;
        end
        else
        begin
            count     <= (count == TERM) ? '0 : count + 1'b1;
            sample_en <= (count == TERM);
        end
    end

    // Strobe lasts one clock only
    a_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        sample_en |=> !sample_en);

endmodule

`default_nettype wire

// ==== verilog/dds_tone.sv ====
/* Phase accumulator tone generator with a 1024-entry sine lookup */

`timescale 1ns/1ns
`default_nettype none

`include "dsp_settings.svh"

module dds_tone
(
    input  wire             clk,
    input  wire             rst_n,
    input  wire             sample_en,
    input  wire  dsp_pkg::phase_t inc,
    output dsp_pkg::sample_t      tone
);

    import dsp_pkg::*;

    localparam int LUT_DEPTH = 1 << `LUT_AW;

    ////////////////////////////////////////////////////////////
    // Sine table
    ////////////////////////////////////////////////////////////

    // Constant contents, synthesizes to a ROM
    sample_t sine_lut [0:LUT_DEPTH-1];

    for (genvar i = 0; i < LUT_DEPTH; i++)
    begin : g_lut
        assign sine_lut[i] = sine_at(i);
    end

    ////////////////////////////////////////////////////////////
    // Phase accumulator
    ////////////////////////////////////////////////////////////

    phase_t             phase;
    logic [`LUT_AW-1:0] lut_idx;

    // Top phase bits address the table, low bits give fine frequency
    assign lut_idx = phase[`PHASE_W-1 -: `LUT_AW];

    // Lookup uses the phase before the increment
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            phase <= '0;
            tone  <= '0;
        end
        else if (sample_en)
        begin
            tone  <= sine_lut[lut_idx];
            // Natural wrap of the phase word
            phase <= phase + inc;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/tone_mixer.sv ====
/* Registered two-tone adder with external sample bypass */

`timescale 1ns/1ns
`default_nettype none

module tone_mixer
(
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    sample_en,
    input  wire                    ext_mode,
    input  wire  dsp_pkg::sample_t sample_in,
    input  wire  dsp_pkg::sample_t tone_a,
    input  wire  dsp_pkg::sample_t tone_b,
    output dsp_pkg::mix_t          mix_out
);

    import dsp_pkg::*;

    // Operands sign-extended to the mix width
    mix_t tone_sum;

    assign tone_sum = mix_t'(tone_a) + mix_t'(tone_b);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            mix_out <= '0;
        end
        else if (sample_en)
        begin
            // External sample replaces both tones
            mix_out <= ext_mode ? mix_t'(sample_in) : tone_sum;
        end
    end

    // Tones only move right after a strobe
    a_tones_held: assert property (@(posedge clk) disable iff (!rst_n)
        !$past(sample_en) |-> $stable(tone_a) && $stable(tone_b));

endmodule

`default_nettype wire

// ==== verilog/fir_lowpass.sv ====
/* Symmetric 17-tap low-pass FIR, delay line, pre-adder and
   multiply-accumulate with registered output and valid */

`timescale 1ns/1ns
`default_nettype none

`include "dsp_settings.svh"

module fir_lowpass
(
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 sample_en,
    input  wire  dsp_pkg::mix_t mix_in,
    output dsp_pkg::acc_t       filt_out,
    output logic                out_valid
);

    import dsp_pkg::*;

    // Mirrored pairs plus the centre tap
    localparam int HALF = (`NUM_TAPS + 1) / 2;

    // Pre-add result, one bit over the mix width
    typedef logic signed [17:0] pre_t;

    ////////////////////////////////////////////////////////////
    // Delay line
    ////////////////////////////////////////////////////////////

    // Older samples, input itself acts as tap 0
    mix_t dly [0:`NUM_TAPS-2];
    mix_t win [0:`NUM_TAPS-1];

    always_comb
    begin
        win[0] = mix_in;
        for (int i = 1; i < `NUM_TAPS; i++)
        begin
            win[i] = dly[i-1];
        end
    end

    // Cleared so the first outputs see zero history
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < `NUM_TAPS - 1; i++)
            begin
                dly[i] <= '0;
            end
        end
        else if (sample_en)
        begin
            dly[0] <= mix_in;
            for (int i = 1; i < `NUM_TAPS - 1; i++)
            begin
                dly[i] <= dly[i-1];
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Pre-add and multiply-accumulate
    ////////////////////////////////////////////////////////////

    acc_t acc_sum;

    always_comb
    begin
        pre_t pre;
        acc_sum = '0;
        for (int i = 0; i < HALF; i++)
        begin
            // Centre tap has no mirror partner
            if (i == `NUM_TAPS - 1 - i)
                pre = pre_t'(win[i]);
            else
                pre = pre_t'(win[i]) + pre_t'(win[`NUM_TAPS-1-i]);
            acc_sum = acc_sum + acc_t'(pre) * acc_t'(LP_COEFS[i]);
        end
    end

    // Output and valid land one clock after the strobe edge
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            filt_out  <= '0;
            out_valid <= 1'b0;
        end
        else
        begin
            out_valid <= sample_en;
            if (sample_en)
                filt_out <= acc_sum;
        end
    end

    // Tap 0 is the live input, held steady between strobes
    a_input_held: assert property (@(posedge clk) disable iff (!rst_n)
        !$past(sample_en) |-> $stable(mix_in));

endmodule

`default_nettype wire

// ==== verilog/tone_filter_top.sv ====
/* Two-tone generator, mixer and low-pass FIR on a shared sample strobe */

`timescale 1ns/1ns
`default_nettype none

module tone_filter_top
(
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire  dsp_pkg::phase_t  inc_a,
    input  wire  dsp_pkg::phase_t  inc_b,
    input  wire                    ext_mode,
    input  wire  dsp_pkg::sample_t sample_in,
    output wire  dsp_pkg::mix_t    mix_out,
    output wire  dsp_pkg::acc_t    filt_out,
    output wire                    out_valid
);

    import dsp_pkg::*;

    logic    sample_en;
    sample_t tone_a;
    sample_t tone_b;

    // Sample rate strobe, clk / SAMPLE_DIV
    sample_clock_enable u_sample_clock_enable (
        .clk       (clk),
        .rst_n     (rst_n),
        .sample_en (sample_en)
    );

    // High tone, 140 kHz at the reference increment
    dds_tone tone_a_gen (
        .clk       (clk),
        .rst_n     (rst_n),
        .sample_en (sample_en),
        .inc       (inc_a),
        .tone      (tone_a)
    );

    // Low tone, 10 kHz at the reference increment
    dds_tone tone_b_gen (
        .clk       (clk),
        .rst_n     (rst_n),
        .sample_en (sample_en),
        .inc       (inc_b),
        .tone      (tone_b)
    );

    tone_mixer u_tone_mixer (
        .clk       (clk),
        .rst_n     (rst_n),
        .sample_en (sample_en),
        .ext_mode  (ext_mode),
        .sample_in (sample_in),
        .tone_a    (tone_a),
        .tone_b    (tone_b),
        .mix_out   (mix_out)
    );

    // Low-pass keeps the low tone, removes the high one
    fir_lowpass u_fir_lowpass (
        .clk       (clk),
        .rst_n     (rst_n),
        .sample_en (sample_en),
        .mix_in    (mix_out),
        .filt_out  (filt_out),
        .out_valid (out_valid)
    );

endmodule

`default_nettype wire

// ==== test/tone_filter_checker.sv ====
/* Reference model of the tone sum and the FIR, per-pulse comparisons
   and one result line per stimulus row */

`timescale 1ns/1ns
`default_nettype none

`include "dsp_settings.svh"

module tone_filter_checker
(
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire  dsp_pkg::phase_t  inc_a,
    input  wire  dsp_pkg::phase_t  inc_b,
    input  wire                    ext_mode,
    input  wire  dsp_pkg::mix_t    mix_out,
    input  wire  dsp_pkg::acc_t    filt_out,
    input  wire                    out_valid,
    input  wire  [7:0]             row_id,
    input  wire  [1:0]             pattern,
    input  wire  dsp_pkg::sample_t amp,
    input  wire                    row_end,
    output int                     rows_passed,
    output int                     rows_failed
);

    import dsp_pkg::*;

    localparam logic [1:0] PAT_IMPULSE = 2'd1;
    localparam logic [1:0] PAT_STEP    = 2'd2;
    localparam real        PI_REF      = 3.14159265358979323846;

    // Observed mixer values, one per out_valid pulse
    int     hist [0:255];
    // Clocks since reset release
    int     cyc;
    int     last_cyc;
    // Pulse index within the row
    int     n;
    int     row_errs;
    longint coef_sum;

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    // Table rule, rounded half away from zero
    function automatic int sine_model(input int idx);
        real v;
        v = 32767.0 * $sin(2.0 * PI_REF * real'(idx) / real'(1 << `LUT_AW));
        return (v >= 0.0) ? $rtoi(v + 0.5) : -$rtoi(0.5 - v);
    endfunction

    // Phase after k increments, wrapped to PHASE_W bits
    function automatic int tone_model(input phase_t inc, input int k);
        phase_t ph;
        ph = phase_t'(k * inc);
        return sine_model(int'(ph >> (`PHASE_W - `LUT_AW)));
    endfunction

    task automatic log_mismatch(input string msg);
        $display("CHECK FAILED at %0t: row %0d, pulse %0d, %s", $time, row_id, n, msg);
        row_errs++;
    endtask

    initial
    begin
        rows_passed = 0;
        rows_failed = 0;
        row_errs    = 0;
        coef_sum    = 0;
        for (int i = 0; i < `NUM_TAPS; i++)
            coef_sum += LP_COEFS[i];
    end

    ////////////////////////////////////////////////////////////
    // Per-pulse comparisons
    ////////////////////////////////////////////////////////////

    always @(posedge clk)
    begin
        longint exp_filt;
        int     exp_mix;
        if (!rst_n)
        begin
            if (out_valid)
                log_mismatch("out_valid high during reset");
            cyc      = 0;
            last_cyc = 0;
            n        = 0;
        end
        else
        begin
            if (out_valid)
            begin
                // First pulse one clock after the first strobe
                if (n == 0 && cyc != `SAMPLE_DIV + 1)
                    log_mismatch($sformatf("first pulse after %0d clocks", cyc));
                else if (n > 0 && cyc - last_cyc != `SAMPLE_DIV)
                    log_mismatch($sformatf("pulse spacing %0d clocks", cyc - last_cyc));
                last_cyc = cyc;

                // Mixer output, tones lag one strobe
                if (!ext_mode)
                    exp_mix = (n == 0) ? 0 : tone_model(inc_a, n - 1) + tone_model(inc_b, n - 1);
                else if (pattern == PAT_IMPULSE)
                    exp_mix = (n == 0) ? int'(amp) : 0;
                else
                    exp_mix = int'(amp);
                if (int'(mix_out) != exp_mix)
                    log_mismatch($sformatf("mix_out %0d, expected %0d", mix_out, exp_mix));

                // Filter over the observed history, older values zero
                exp_filt = 0;
                for (int i = 0; i < `NUM_TAPS; i++)
                begin
                    if (n - 1 - i >= 0)
                        exp_filt += longint'(LP_COEFS[i]) * hist[n - 1 - i];
                end
                if (longint'(filt_out) != exp_filt)
                    log_mismatch($sformatf("filt_out %0d, expected %0d", filt_out, exp_filt));

                // Impulse gives the scaled coefficients, then zeros
                if (ext_mode && pattern == PAT_IMPULSE)
                begin
                    exp_filt = 0;
                    if (n >= 1 && n <= `NUM_TAPS)
                        exp_filt = longint'(amp) * LP_COEFS[n - 1];
                    if (longint'(filt_out) != exp_filt)
                        log_mismatch($sformatf("impulse tap %0d, expected %0d", n - 1, exp_filt));
                end

                // Step settles once the line is full
                if (ext_mode && pattern == PAT_STEP && n >= `NUM_TAPS + 2)
                begin
                    if (longint'(filt_out) != longint'(amp) * coef_sum)
                        log_mismatch($sformatf("step output %0d not settled", filt_out));
                end

                hist[n] = int'(mix_out);
                n++;
            end
            cyc++;
        end

        // One line per row
        if (row_end)
        begin
            if (row_errs == 0)
            begin
                rows_passed++;
                $display("Row %0d passed, %0d samples", row_id, n);
            end
            else
            begin
                rows_failed++;
                $display("Row %0d failed with %0d mismatches", row_id, row_errs);
            end
            row_errs = 0;
        end
    end

endmodule

`default_nettype wire

// ==== test/tone_filter_tb.sv ====
/* Testbench top with clock, reset, stimulus table and row loop,
   DUT and checker instances and the closing report */

`timescale 1ns/1ns
`default_nettype none

`include "dsp_settings.svh"

module tone_filter_tb;

    import dsp_pkg::*;

    localparam logic [1:0] PAT_NONE    = 2'd0;
    localparam logic [1:0] PAT_IMPULSE = 2'd1;
    localparam logic [1:0] PAT_STEP    = 2'd2;
    localparam int         NUM_ROWS    = 4;
    // Clocks allowed between two out_valid pulses
    localparam int         PULSE_TIMEOUT = 3 * `SAMPLE_DIV;

    typedef struct packed {
        logic       ext;
        phase_t     inc_a;
        phase_t     inc_b;
        logic [1:0] pattern;
        sample_t    amp;
        logic [7:0] count;
    } row_t;

    row_t       stim [NUM_ROWS];

    logic       clk;
    logic       rst_n;
    phase_t     inc_a;
    phase_t     inc_b;
    logic       ext_mode;
    sample_t    sample_in;
    mix_t       mix_out;
    acc_t       filt_out;
    logic       out_valid;
    logic [7:0] row_id;
    logic [1:0] pattern;
    sample_t    amp;
    logic       row_end;
    logic       timed_out;
    int         rows_passed;
    int         rows_failed;

    // 20 ns period
    always #10 clk = ~clk;

    tone_filter_top DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .inc_a     (inc_a),
        .inc_b     (inc_b),
        .ext_mode  (ext_mode),
        .sample_in (sample_in),
        .mix_out   (mix_out),
        .filt_out  (filt_out),
        .out_valid (out_valid)
    );

    tone_filter_checker u_checker (
        .clk         (clk),
        .rst_n       (rst_n),
        .inc_a       (inc_a),
        .inc_b       (inc_b),
        .ext_mode    (ext_mode),
        .mix_out     (mix_out),
        .filt_out    (filt_out),
        .out_valid   (out_valid),
        .row_id      (row_id),
        .pattern     (pattern),
        .amp         (amp),
        .row_end     (row_end),
        .rows_passed (rows_passed),
        .rows_failed (rows_failed)
    );

    function automatic row_t make_row(input logic ext, input phase_t ia, input phase_t ib,
                                      input logic [1:0] pat, input sample_t a,
                                      input logic [7:0] cnt);
        row_t r;
        r.ext     = ext;
        r.inc_a   = ia;
        r.inc_b   = ib;
        r.pattern = pat;
        r.amp     = a;
        r.count   = cnt;
        return r;
    endfunction

    ////////////////////////////////////////////////////////////
    // One table row: reset, then count out_valid pulses
    ////////////////////////////////////////////////////////////

    task automatic run_row(input int r);
        int pulses;
        int waited;
        @(posedge clk);
        rst_n     <= 1'b0;
        ext_mode  <= stim[r].ext;
        inc_a     <= stim[r].inc_a;
        inc_b     <= stim[r].inc_b;
        sample_in <= (stim[r].pattern != PAT_NONE) ? stim[r].amp : '0;
        row_id    <= 8'(r);
        pattern   <= stim[r].pattern;
        amp       <= stim[r].amp;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        pulses = 0;
        waited = 0;
        while (pulses < int'(stim[r].count) && !timed_out)
        begin
            @(posedge clk);
            waited++;
            if (out_valid)
            begin
                pulses++;
                waited = 0;
                // Impulse lasts for the first strobe only
                if (stim[r].pattern == PAT_IMPULSE)
                    sample_in <= '0;
            end
            else if (waited > PULSE_TIMEOUT)
            begin
                $display("Row %0d: out_valid stopped arriving after %0d pulses", r, pulses);
                timed_out = 1'b1;
            end
        end
        if (!timed_out)
        begin
            row_end <= 1'b1;
            @(posedge clk);
            row_end <= 1'b0;
        end
    endtask

    initial
    begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        inc_a     = '0;
        inc_b     = '0;
        ext_mode  = 1'b0;
        sample_in = '0;
        row_id    = '0;
        pattern   = PAT_NONE;
        amp       = '0;
        row_end   = 1'b0;
        timed_out = 1'b0;

        // Reference tones, equal tones, impulse, step
        stim[0] = make_row(1'b0, 16'h23D7, 16'h028F, PAT_NONE, 16'sd0, 8'd60);
        stim[1] = make_row(1'b0, 16'h23D7, 16'h23D7, PAT_NONE, 16'sd0, 8'd24);
        stim[2] = make_row(1'b1, 16'h0000, 16'h0000, PAT_IMPULSE, 16'sd1000, 8'd24);
        stim[3] = make_row(1'b1, 16'h23D7, 16'h028F, PAT_STEP, -16'sd20000, 8'd30);

        for (int r = 0; r < NUM_ROWS; r++)
        begin
            if (!timed_out)
                run_row(r);
        end

        @(posedge clk);
        $display("Rows passed: %0d, rows failed: %0d", rows_passed, rows_failed);
        if (timed_out || rows_failed != 0 || rows_passed != NUM_ROWS)
        begin
            $display("TEST FAILED");
        end
        else
        begin
            $display("TEST OK");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tone_filter.f ====
+incdir+verilog
verilog/dsp_pkg.sv
verilog/sample_clock_enable.sv
verilog/dds_tone.sv
verilog/tone_mixer.sv
verilog/fir_lowpass.sv
verilog/tone_filter_top.sv
test/tone_filter_checker.sv
test/tone_filter_tb.sv
